//--- common/rvfi_check_pkg.sv
// RV32I subset only, 32-bit fixed; no loads, stores, CSRs, traps or compressed encodings
package rvfi_check_pkg;

  localparam int unsigned xlen        = 32;
  localparam int unsigned order_width = 64;
  localparam int unsigned count_width = 16;
  localparam int unsigned num_regs    = 32;
  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;

  // Bit positions inside the report mismatch mask
  localparam int unsigned mis_order       = 0;
  localparam int unsigned mis_pc_rdata    = 1;
  localparam int unsigned mis_rs1         = 2;
  localparam int unsigned mis_rs2         = 3;
  localparam int unsigned mis_rd          = 4;
  localparam int unsigned mis_pc_wdata    = 5;
  localparam int unsigned mis_unsupported = 6;
  localparam int unsigned mis_width       = 7;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // The branch immediate is scattered over the upper bits and the rd slot
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } insn_u;

  typedef struct packed {
    logic [order_width-1:0] order;
    logic [xlen-1:0]        insn;
    logic                   trap;
    logic [xlen-1:0]        pc_rdata;
    logic [xlen-1:0]        pc_wdata;
    logic [4:0]             rs1_addr;
    logic [4:0]             rs2_addr;
    logic [xlen-1:0]        rs1_rdata;
    logic [xlen-1:0]        rs2_rdata;
    logic [4:0]             rd_addr;
    logic [xlen-1:0]        rd_wdata;
  } rvfi_rec_t;

  // The last six encodings are branch conditions, not ALU results
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and, alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
  } alu_op_e;

  typedef enum logic [1:0] {
    src_rs1, src_pc, src_zero
  } src_a_e;

  typedef enum logic [1:0] {
    ctl_none, ctl_branch, ctl_jal, ctl_jalr
  } ctl_e;

  typedef struct packed {
    rvfi_rec_t       rec;
    alu_op_e         alu_op;
    src_a_e          src_a;
    logic            src_b_imm;
    logic [xlen-1:0] imm;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic            rd_we;
    logic            uses_rs1;
    logic            uses_rs2;
    ctl_e            ctl;
    logic            unsupported;
  } dec_op_t;

  typedef struct packed {
    rvfi_rec_t       rec;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] rd_data;
    logic [xlen-1:0] next_pc;
    logic            rd_we;
    logic            uses_rs1;
    logic            uses_rs2;
    logic            order_mis;
    logic            pc_mis;
    logic            unsupported;
  } exp_t;

  typedef struct packed {
    logic [order_width-1:0] order;
    logic [mis_width-1:0]   mismatch;
    logic [xlen-1:0]        exp_rd;
    logic [xlen-1:0]        exp_pc;
  } report_t;

endpackage

//--- rtl/insn_decode.sv
// Decodes RV32I ALU, LUI, AUIPC, JAL, JALR and branches; anything else or a trap is unsupported
module insn_decode (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  rvfi_check_pkg::rvfi_rec_t in_i,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output rvfi_check_pkg::dec_op_t   out_o
);

  rvfi_check_pkg::insn_u   insn;
  rvfi_check_pkg::dec_op_t dec_d;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic                    legal;

  function automatic rvfi_check_pkg::alu_op_e alu_of(logic [2:0] f3, logic alt);
    rvfi_check_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rvfi_check_pkg::alu_sub : rvfi_check_pkg::alu_add;
      3'b001:  op = rvfi_check_pkg::alu_sll;
      3'b010:  op = rvfi_check_pkg::alu_slt;
      3'b011:  op = rvfi_check_pkg::alu_sltu;
      3'b100:  op = rvfi_check_pkg::alu_xor;
      3'b101:  op = alt ? rvfi_check_pkg::alu_sra : rvfi_check_pkg::alu_srl;
      3'b110:  op = rvfi_check_pkg::alu_or;
      default: op = rvfi_check_pkg::alu_and;
    endcase
    return op;
  endfunction

  assign insn   = in_i.insn;
  assign funct3 = insn.r_fmt.funct3;
  assign funct7 = insn.r_fmt.funct7;

  always_comb begin
    dec_d          = '0;
    dec_d.rec      = in_i;
    dec_d.rs1      = insn.r_fmt.rs1;
    dec_d.rs2      = insn.r_fmt.rs2;
    dec_d.rd       = insn.r_fmt.rd;
    dec_d.src_a    = rvfi_check_pkg::src_rs1;
    dec_d.ctl      = rvfi_check_pkg::ctl_none;
    dec_d.alu_op   = rvfi_check_pkg::alu_add;
    legal          = 1'b1;
    case (insn.r_fmt.opcode)
      rvfi_check_pkg::op_reg: begin
        // Only SUB and SRA use the alternate funct7
        legal = (funct7 == 7'h00) ||
                (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
        dec_d.alu_op   = alu_of(funct3, funct7[5]);
        dec_d.rd_we    = 1'b1;
        dec_d.uses_rs1 = 1'b1;
        dec_d.uses_rs2 = 1'b1;
      end
      rvfi_check_pkg::op_imm: begin
        if (funct3 == 3'b001) begin
          legal = (funct7 == 7'h00);
        end else if (funct3 == 3'b101) begin
          legal = (funct7 == 7'h00) || (funct7 == 7'h20);
        end
        dec_d.alu_op    = alu_of(funct3, funct3 == 3'b101 && funct7[5]);
        dec_d.src_b_imm = 1'b1;
        dec_d.imm       = {{20{insn.i_fmt.imm[11]}}, insn.i_fmt.imm};
        dec_d.rd_we     = 1'b1;
        dec_d.uses_rs1  = 1'b1;
      end
      rvfi_check_pkg::op_lui, rvfi_check_pkg::op_auipc: begin
        dec_d.src_a     = (insn.u_fmt.opcode == rvfi_check_pkg::op_lui) ?
                          rvfi_check_pkg::src_zero : rvfi_check_pkg::src_pc;
        dec_d.src_b_imm = 1'b1;
        dec_d.imm       = {insn.u_fmt.imm, 12'b0};
        dec_d.rd_we     = 1'b1;
      end
      rvfi_check_pkg::op_jal: begin
        dec_d.ctl   = rvfi_check_pkg::ctl_jal;
        dec_d.imm   = {{11{insn.j_fmt.imm_20}}, insn.j_fmt.imm_20, insn.j_fmt.imm_19_12,
                       insn.j_fmt.imm_11, insn.j_fmt.imm_10_1, 1'b0};
        dec_d.rd_we = 1'b1;
      end
      rvfi_check_pkg::op_jalr: begin
        legal          = (funct3 == 3'b000);
        dec_d.ctl      = rvfi_check_pkg::ctl_jalr;
        dec_d.imm      = {{20{insn.i_fmt.imm[11]}}, insn.i_fmt.imm};
        dec_d.rd_we    = 1'b1;
        dec_d.uses_rs1 = 1'b1;
      end
      rvfi_check_pkg::op_branch: begin
        legal          = (funct3 != 3'b010) && (funct3 != 3'b011);
        dec_d.ctl      = rvfi_check_pkg::ctl_branch;
        dec_d.imm      = {{19{insn.b_fmt.imm_12}}, insn.b_fmt.imm_12, insn.b_fmt.imm_11,
                          insn.b_fmt.imm_10_5, insn.b_fmt.imm_4_1, 1'b0};
        dec_d.uses_rs1 = 1'b1;
        dec_d.uses_rs2 = 1'b1;
        case (funct3)
          3'b000:  dec_d.alu_op = rvfi_check_pkg::alu_beq;
          3'b001:  dec_d.alu_op = rvfi_check_pkg::alu_bne;
          3'b100:  dec_d.alu_op = rvfi_check_pkg::alu_blt;
          3'b101:  dec_d.alu_op = rvfi_check_pkg::alu_bge;
          3'b110:  dec_d.alu_op = rvfi_check_pkg::alu_bltu;
          default: dec_d.alu_op = rvfi_check_pkg::alu_bgeu;
        endcase
      end
      default: legal = 1'b0;
    endcase
    dec_d.unsupported = in_i.trap || !legal;
    // A write to x0 is no write at all
    if (dec_d.rd == 5'd0 || dec_d.unsupported) begin
      dec_d.rd_we = 1'b0;
    end
  end

  assign in_ready_o = !out_valid_o || out_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      out_o <= dec_d;
    end
  end

endmodule

//--- rtl/shadow_execute.sv
// Shadow state advances once per accepted record and is never resynchronized to the core
module shadow_execute (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  rvfi_check_pkg::dec_op_t in_i,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output rvfi_check_pkg::exp_t    out_o
);

  logic [rvfi_check_pkg::xlen-1:0]        regs_q [rvfi_check_pkg::num_regs];
  logic [rvfi_check_pkg::xlen-1:0]        pc_q;
  logic [rvfi_check_pkg::order_width-1:0] order_q;
  logic [rvfi_check_pkg::xlen-1:0]        rs1_val;
  logic [rvfi_check_pkg::xlen-1:0]        rs2_val;
  logic [rvfi_check_pkg::xlen-1:0]        op_a;
  logic [rvfi_check_pkg::xlen-1:0]        op_b;
  logic [rvfi_check_pkg::xlen-1:0]        alu_res;
  logic [rvfi_check_pkg::xlen-1:0]        pc_plus4;
  logic [rvfi_check_pkg::xlen-1:0]        jalr_sum;
  logic [rvfi_check_pkg::xlen-1:0]        next_pc;
  logic [rvfi_check_pkg::xlen-1:0]        rd_val;
  logic                                   taken;
  logic                                   accept;
  rvfi_check_pkg::exp_t                   exp_d;

  assign rs1_val  = regs_q[in_i.rs1];
  assign rs2_val  = regs_q[in_i.rs2];
  assign pc_plus4 = pc_q + 32'd4;
  assign jalr_sum = rs1_val + in_i.imm;

  always_comb begin
    case (in_i.src_a)
      rvfi_check_pkg::src_pc:   op_a = pc_q;
      rvfi_check_pkg::src_zero: op_a = '0;
      default:                  op_a = rs1_val;
    endcase
    op_b = in_i.src_b_imm ? in_i.imm : rs2_val;
  end

  always_comb begin
    taken = 1'b0;
    case (in_i.alu_op)
      rvfi_check_pkg::alu_sub:  alu_res = op_a - op_b;
      rvfi_check_pkg::alu_sll:  alu_res = op_a << op_b[4:0];
      rvfi_check_pkg::alu_slt:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      rvfi_check_pkg::alu_sltu: alu_res = {31'b0, op_a < op_b};
      rvfi_check_pkg::alu_xor:  alu_res = op_a ^ op_b;
      rvfi_check_pkg::alu_srl:  alu_res = op_a >> op_b[4:0];
      rvfi_check_pkg::alu_sra:  alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
      rvfi_check_pkg::alu_or:   alu_res = op_a | op_b;
      rvfi_check_pkg::alu_and:  alu_res = op_a & op_b;
      default:                  alu_res = op_a + op_b;
    endcase
    case (in_i.alu_op)
      rvfi_check_pkg::alu_beq:  taken = (rs1_val == rs2_val);
      rvfi_check_pkg::alu_bne:  taken = (rs1_val != rs2_val);
      rvfi_check_pkg::alu_blt:  taken = ($signed(rs1_val) < $signed(rs2_val));
      rvfi_check_pkg::alu_bge:  taken = ($signed(rs1_val) >= $signed(rs2_val));
      rvfi_check_pkg::alu_bltu: taken = (rs1_val < rs2_val);
      rvfi_check_pkg::alu_bgeu: taken = (rs1_val >= rs2_val);
      default:                  taken = 1'b0;
    endcase
  end

  always_comb begin
    rd_val = alu_res;
    case (in_i.ctl)
      rvfi_check_pkg::ctl_branch: next_pc = taken ? pc_q + in_i.imm : pc_plus4;
      rvfi_check_pkg::ctl_jal: begin
        next_pc = pc_q + in_i.imm;
        rd_val  = pc_plus4;
      end
      rvfi_check_pkg::ctl_jalr: begin
        next_pc = {jalr_sum[rvfi_check_pkg::xlen-1:1], 1'b0};
        rd_val  = pc_plus4;
      end
      default: next_pc = pc_plus4;
    endcase
  end

  always_comb begin
    exp_d             = '0;
    exp_d.rec         = in_i.rec;
    exp_d.rs1_data    = rs1_val;
    exp_d.rs2_data    = rs2_val;
    exp_d.rd_data     = in_i.rd_we ? rd_val : '0;
    // An unsupported record leaves the pc where the model has it
    exp_d.next_pc     = in_i.unsupported ? pc_q : next_pc;
    exp_d.rd_we       = in_i.rd_we;
    exp_d.uses_rs1    = in_i.uses_rs1;
    exp_d.uses_rs2    = in_i.uses_rs2;
    exp_d.order_mis   = (in_i.rec.order != order_q);
    exp_d.pc_mis      = (in_i.rec.pc_rdata != pc_q);
    exp_d.unsupported = in_i.unsupported;
  end

  assign in_ready_o = !out_valid_o || out_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      pc_q    <= rvfi_check_pkg::reset_pc;
      order_q <= '0;
      for (int i = 0; i < rvfi_check_pkg::num_regs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (accept) begin
      // The order follows the core even when the record is unsupported
      order_q <= in_i.rec.order + 1'b1;
      if (!in_i.unsupported) begin
        pc_q <= next_pc;
        if (in_i.rd_we) begin
          regs_q[in_i.rd] <= rd_val;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      out_o <= exp_d;
    end
  end

endmodule

//--- rtl/commit_compare.sv
// Counters saturate at their maximum and only count reports taken by the consumer
module commit_compare (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   in_valid_i,
  output logic                                   in_ready_o,
  input  rvfi_check_pkg::exp_t                   in_i,
  output logic                                   rpt_valid_o,
  input  logic                                   rpt_ready_i,
  output rvfi_check_pkg::report_t                rpt_o,
  output logic [rvfi_check_pkg::count_width-1:0] checked_count_o,
  output logic [rvfi_check_pkg::count_width-1:0] mismatch_count_o
);

  logic [rvfi_check_pkg::mis_width-1:0] mis;
  logic                                 handout;

  always_comb begin
    mis = '0;
    mis[rvfi_check_pkg::mis_order]    = in_i.order_mis;
    mis[rvfi_check_pkg::mis_pc_rdata] = in_i.pc_mis;
    if (in_i.unsupported) begin
      mis[rvfi_check_pkg::mis_unsupported] = 1'b1;
    end else begin
      mis[rvfi_check_pkg::mis_rs1] = in_i.uses_rs1 && (in_i.rec.rs1_rdata != in_i.rs1_data);
      mis[rvfi_check_pkg::mis_rs2] = in_i.uses_rs2 && (in_i.rec.rs2_rdata != in_i.rs2_data);
      mis[rvfi_check_pkg::mis_rd]  = in_i.rd_we && (in_i.rec.rd_wdata != in_i.rd_data);
      mis[rvfi_check_pkg::mis_pc_wdata] = (in_i.rec.pc_wdata != in_i.next_pc);
    end
  end

  assign in_ready_o = !rpt_valid_o || rpt_ready_i;
  assign handout    = rpt_valid_o && rpt_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      rpt_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      rpt_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      rpt_o.order    <= in_i.rec.order;
      rpt_o.mismatch <= mis;
      rpt_o.exp_rd   <= in_i.rd_data;
      rpt_o.exp_pc   <= in_i.next_pc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      checked_count_o  <= '0;
      mismatch_count_o <= '0;
    end else if (handout) begin
      if (checked_count_o != '1) begin
        checked_count_o <= checked_count_o + 1'b1;
      end
      if (rpt_o.mismatch != '0 && mismatch_count_o != '1) begin
        mismatch_count_o <= mismatch_count_o + 1'b1;
      end
    end
  end

endmodule

//--- rtl/rvfi_checker_top.sv
// One RVFI commit port in, one report per record out, three records in flight at most
module rvfi_checker_top (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   rec_valid_i,
  output logic                                   rec_ready_o,
  input  rvfi_check_pkg::rvfi_rec_t              rec_i,
  output logic                                   rpt_valid_o,
  input  logic                                   rpt_ready_i,
  output rvfi_check_pkg::report_t                rpt_o,
  output logic [rvfi_check_pkg::count_width-1:0] checked_count_o,
  output logic [rvfi_check_pkg::count_width-1:0] mismatch_count_o
);

  logic                    dec_valid;
  logic                    dec_ready;
  rvfi_check_pkg::dec_op_t dec_op;
  logic                    exp_valid;
  logic                    exp_ready;
  rvfi_check_pkg::exp_t    exp_rec;

  insn_decode u_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (rec_valid_i),
    .in_ready_o  (rec_ready_o),
    .in_i        (rec_i),
    .out_valid_o (dec_valid),
    .out_ready_i (dec_ready),
    .out_o       (dec_op)
  );

  shadow_execute u_execute (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (dec_valid),
    .in_ready_o  (dec_ready),
    .in_i        (dec_op),
    .out_valid_o (exp_valid),
    .out_ready_i (exp_ready),
    .out_o       (exp_rec)
  );

  commit_compare u_compare (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .in_valid_i       (exp_valid),
    .in_ready_o       (exp_ready),
    .in_i             (exp_rec),
    .rpt_valid_o      (rpt_valid_o),
    .rpt_ready_i      (rpt_ready_i),
    .rpt_o            (rpt_o),
    .checked_count_o  (checked_count_o),
    .mismatch_count_o (mismatch_count_o)
  );

endmodule

//--- testbench/tb_rvfi_tasks.svh
// Included inside the testbench top; inputs change only on the falling clock edge

  task automatic abort_run(input string why);
    $display("Regression failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at time %0t: %s expected %h got %h", $time, what, exp, got);
      abort_run("a checked value did not match its expected value");
    end
  endtask

  // Leaves valid high so that the next record follows back to back
  task automatic send_rec(input rvfi_check_pkg::rvfi_rec_t r);
    int waited;
    waited = 0;
    @(negedge clk_i);
    rec_valid_i = 1'b1;
    rec_i       = r;
    #1;
    while (!rec_ready_o) begin
      waited++;
      if (waited > wait_limit) begin
        abort_run("timed out waiting for rec_ready_o");
      end
      @(negedge clk_i);
      #1;
    end
    @(posedge clk_i);
  endtask

  // Holds rpt_ready_i low for gap cycles before taking the next report
  task automatic expect_rpt(input rvfi_check_pkg::report_t e, input int gap);
    int waited;
    waited = 0;
    repeat (gap) begin
      @(negedge clk_i);
      rpt_ready_i = 1'b0;
    end
    @(negedge clk_i);
    rpt_ready_i = 1'b1;
    #1;
    while (!rpt_valid_o) begin
      waited++;
      if (waited > wait_limit) begin
        abort_run("timed out waiting for rpt_valid_o");
      end
      @(negedge clk_i);
      #1;
    end
    check_eq(64'(rpt_o.order), 64'(e.order), "report order");
    check_eq(64'(rpt_o.mismatch), 64'(e.mismatch), "report mismatch mask");
    check_eq(64'(rpt_o.exp_rd), 64'(e.exp_rd), "report expected rd");
    check_eq(64'(rpt_o.exp_pc), 64'(e.exp_pc), "report expected next pc");
    n_checked++;
    if (e.mismatch != '0) begin
      n_mis++;
    end
    @(posedge clk_i);
  endtask

  task automatic run_queue(input int gap_max);
    fork
      begin
        foreach (rec_q[i]) begin
          send_rec(rec_q[i]);
        end
        @(negedge clk_i);
        rec_valid_i = 1'b0;
      end
      begin
        foreach (exp_q[i]) begin
          expect_rpt(exp_q[i], $urandom_range(gap_max, 0));
        end
      end
    join
    rec_q.delete();
    exp_q.delete();
  endtask

  task automatic check_counts();
    @(negedge clk_i);
    check_eq(64'(checked_count_o), 64'(n_checked), "checked_count_o");
    check_eq(64'(mismatch_count_o), 64'(n_mis), "mismatch_count_o");
  endtask

//--- testbench/tb_rvfi_checker.sv
// Compile after the RTL package; stimulus is seeded, so every run replays the same records
module tb_rvfi_checker;

  localparam int wait_limit = 1000;

  logic                                   clk_i;
  logic                                   rst_ni;
  logic                                   rec_valid_i;
  logic                                   rec_ready_o;
  rvfi_check_pkg::rvfi_rec_t              rec_i;
  logic                                   rpt_valid_o;
  logic                                   rpt_ready_i;
  rvfi_check_pkg::report_t                rpt_o;
  logic [rvfi_check_pkg::count_width-1:0] checked_count_o;
  logic [rvfi_check_pkg::count_width-1:0] mismatch_count_o;

  // Reference architectural state, advanced as records are built
  logic [31:0]               tb_regs [32];
  logic [31:0]               tb_pc;
  logic [63:0]               tb_order;
  int                        fault;
  int                        n_checked;
  int                        n_mis;
  rvfi_check_pkg::rvfi_rec_t rec_q [$];
  rvfi_check_pkg::report_t   exp_q [$];

  rvfi_checker_top UUT (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .rec_valid_i      (rec_valid_i),
    .rec_ready_o      (rec_ready_o),
    .rec_i            (rec_i),
    .rpt_valid_o      (rpt_valid_o),
    .rpt_ready_i      (rpt_ready_i),
    .rpt_o            (rpt_o),
    .checked_count_o  (checked_count_o),
    .mismatch_count_o (mismatch_count_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  `include "tb_rvfi_tasks.svh"

  function automatic logic [31:0] sext12(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [4:0] rnd_reg();
    return 5'($urandom_range(7, 1));
  endfunction

  // RV32I integer semantics where alt selects SUB and SRA
  function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                          logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Builds a correct record from the model, applies a pending fault, then advances the model
  task automatic push_rec(input logic [31:0] insn, input logic [4:0] rs1, input logic [4:0] rs2,
                          input logic [4:0] rd, input logic [31:0] rd_val,
                          input logic [31:0] next_pc);
    rvfi_check_pkg::rvfi_rec_t r;
    rvfi_check_pkg::report_t   e;
    r           = '0;
    e           = '0;
    r.order     = tb_order;
    r.insn      = insn;
    r.pc_rdata  = tb_pc;
    r.pc_wdata  = next_pc;
    r.rs1_addr  = rs1;
    r.rs2_addr  = rs2;
    r.rs1_rdata = tb_regs[rs1];
    r.rs2_rdata = tb_regs[rs2];
    r.rd_addr   = rd;
    r.rd_wdata  = (rd == 5'd0) ? 32'd0 : rd_val;
    e.exp_rd    = r.rd_wdata;
    e.exp_pc    = next_pc;
    case (fault)
      1: begin
        r.rd_wdata = r.rd_wdata ^ 32'h0000_0100;
        e.mismatch[rvfi_check_pkg::mis_rd] = 1'b1;
      end
      2: begin
        r.rs1_rdata = r.rs1_rdata ^ 32'h0000_0001;
        e.mismatch[rvfi_check_pkg::mis_rs1] = 1'b1;
      end
      3: begin
        r.pc_wdata = r.pc_wdata + 32'd8;
        e.mismatch[rvfi_check_pkg::mis_pc_wdata] = 1'b1;
      end
      4: begin
        r.order = r.order + 64'd1;
        e.mismatch[rvfi_check_pkg::mis_order] = 1'b1;
      end
      default: ;
    endcase
    e.order = r.order;
    if (rd != 5'd0) begin
      tb_regs[rd] = rd_val;
    end
    tb_pc    = next_pc;
    tb_order = r.order + 64'd1;
    fault    = 0;
    rec_q.push_back(r);
    exp_q.push_back(e);
  endtask

  task automatic do_alu(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
    push_rec({1'b0, alt, 5'b0, rs2, rs1, f3, rd, rvfi_check_pkg::op_reg}, rs1, rs2, rd,
             alu_ref(f3, alt, tb_regs[rs1], tb_regs[rs2]), tb_pc + 32'd4);
  endtask

  // Shift immediates carry the SRAI flag in imm bit 10
  task automatic do_alui(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [11:0] imm);
    push_rec({imm, rs1, f3, rd, rvfi_check_pkg::op_imm}, rs1, 5'd0, rd,
             alu_ref(f3, f3 == 3'd5 && imm[10], tb_regs[rs1], sext12(imm)), tb_pc + 32'd4);
  endtask

  task automatic do_upper(input logic auipc, input logic [4:0] rd, input logic [19:0] imm);
    push_rec({imm, rd, auipc ? rvfi_check_pkg::op_auipc : rvfi_check_pkg::op_lui}, 5'd0, 5'd0,
             rd, {imm, 12'b0} + (auipc ? tb_pc : 32'd0), tb_pc + 32'd4);
  endtask

  task automatic do_jal(input logic [4:0] rd, input logic [20:0] off);
    push_rec({off[20], off[10:1], off[11], off[19:12], rd, rvfi_check_pkg::op_jal}, 5'd0, 5'd0,
             rd, tb_pc + 32'd4, tb_pc + {{11{off[20]}}, off});
  endtask

  task automatic do_jalr(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    push_rec({imm, rs1, 3'b000, rd, rvfi_check_pkg::op_jalr}, rs1, 5'd0, rd, tb_pc + 32'd4,
             (tb_regs[rs1] + sext12(imm)) & ~32'd1);
  endtask

  task automatic do_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [12:0] off);
    logic [31:0] a;
    logic [31:0] b;
    logic        taken;
    a = tb_regs[rs1];
    b = tb_regs[rs2];
    case (f3)
      3'd0:    taken = (a == b);
      3'd1:    taken = (a != b);
      3'd4:    taken = ($signed(a) < $signed(b));
      3'd5:    taken = ($signed(a) >= $signed(b));
      3'd6:    taken = (a < b);
      default: taken = (a >= b);
    endcase
    push_rec({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rvfi_check_pkg::op_branch},
             rs1, rs2, 5'd0, 32'd0, taken ? tb_pc + {{19{off[12]}}, off} : tb_pc + 32'd4);
  endtask

  // A trapped or unknown record only moves the order on
  task automatic do_unsup(input logic [31:0] insn, input logic trap);
    rvfi_check_pkg::rvfi_rec_t r;
    rvfi_check_pkg::report_t   e;
    r          = '0;
    e          = '0;
    r.order    = tb_order;
    r.insn     = insn;
    r.trap     = trap;
    r.pc_rdata = tb_pc;
    r.pc_wdata = tb_pc + 32'd4;
    r.rd_addr  = insn[11:7];
    r.rd_wdata = $urandom;
    e.order    = tb_order;
    e.exp_pc   = tb_pc;
    e.mismatch[rvfi_check_pkg::mis_unsupported] = 1'b1;
    tb_order = tb_order + 64'd1;
    rec_q.push_back(r);
    exp_q.push_back(e);
  endtask

  task automatic test_alu_stream();
    for (int i = 1; i < 8; i++) begin
      do_upper(1'b0, 5'(i), 20'($urandom));
      do_alui(3'd0, 5'(i), 5'(i), 12'($urandom));
    end
    for (int f = 0; f < 8; f++) begin
      do_alu(3'(f), 1'b0, 5'(8 + f), rnd_reg(), rnd_reg());
    end
    do_alu(3'd0, 1'b1, 5'd16, rnd_reg(), rnd_reg());
    do_alu(3'd5, 1'b1, 5'd17, rnd_reg(), rnd_reg());
    do_alui(3'd2, 5'd18, rnd_reg(), 12'($urandom));
    do_alui(3'd3, 5'd19, rnd_reg(), 12'($urandom));
    do_alui(3'd4, 5'd20, rnd_reg(), 12'($urandom));
    do_alui(3'd6, 5'd21, rnd_reg(), 12'($urandom));
    do_alui(3'd7, 5'd22, rnd_reg(), 12'($urandom));
    do_alui(3'd1, 5'd23, rnd_reg(), 12'($urandom_range(31, 0)));
    do_alui(3'd5, 5'd24, rnd_reg(), 12'($urandom_range(31, 0)));
    do_alui(3'd5, 5'd25, rnd_reg(), 12'h400 | 12'($urandom_range(31, 0)));
    do_upper(1'b1, 5'd26, 20'($urandom));
    do_alu(3'd0, 1'b0, 5'd0, 5'd1, 5'd2);
    run_queue(0);
    check_counts();
  endtask

  task automatic test_control_flow();
    do_alui(3'd0, 5'd3, 5'd1, 12'h000);
    for (int f = 0; f < 8; f++) begin
      if (f == 2 || f == 3) begin
        continue;
      end
      do_branch(3'(f), 5'd1, 5'd3, 13'h0010);
      do_branch(3'(f), 5'd1, 5'd2, 13'h1ff0);
      do_branch(3'(f), 5'd2, 5'd1, 13'h0100);
    end
    do_jal(5'd1, 21'h000040);
    do_jal(5'd0, 21'h1fffc0);
    do_upper(1'b0, 5'd6, 20'h80001);
    do_jalr(5'd5, 5'd6, 12'h123);
    do_jalr(5'd0, 5'd1, 12'hffc);
    run_queue(0);
    check_counts();
  endtask

  // Each fault is followed by a correct record that reads the faulted result
  task automatic test_faults();
    for (int k = 1; k <= 4; k++) begin
      fault = k;
      do_alu(3'd0, 1'b0, 5'd10, 5'd1, 5'd2);
      do_alu(3'd4, 1'b0, 5'd11, 5'd10, 5'd2);
      run_queue(0);
      check_counts();
    end
  endtask

  task automatic test_unsupported();
    do_alui(3'd0, 5'd4, 5'd1, 12'h055);
    do_unsup({12'h001, 5'd1, 3'b000, 5'd4, rvfi_check_pkg::op_imm}, 1'b1);
    do_unsup({20'($urandom), 5'd4, 7'b0001011}, 1'b0);
    do_alui(3'd0, 5'd9, 5'd4, 12'h000);
    run_queue(0);
    check_counts();
  endtask

  task automatic test_backpressure();
    logic [2:0] f3;
    for (int i = 0; i < 24; i++) begin
      case ($urandom_range(2, 0))
        0: do_alu(3'($urandom), 1'b0, rnd_reg(), rnd_reg(), rnd_reg());
        1: do_alui($urandom_range(1, 0) ? 3'd4 : 3'd0, rnd_reg(), rnd_reg(), 12'($urandom));
        default: begin
          f3 = 3'($urandom_range(5, 0));
          if (f3 > 3'd1) begin
            f3 = f3 + 3'd2;
          end
          do_branch(f3, rnd_reg(), rnd_reg(), 13'h0008);
        end
      endcase
    end
    run_queue(3);
    repeat (4) @(negedge clk_i);
    check_eq(64'(rpt_valid_o), 64'd0, "no report after the stream");
    check_counts();
  endtask

  initial begin
    void'($urandom(85));
    rst_ni      = 1'b1;
    rec_valid_i = 1'b0;
    rec_i       = '0;
    rpt_ready_i = 1'b0;
    fault       = 0;
    n_checked   = 0;
    n_mis       = 0;
    tb_pc       = rvfi_check_pkg::reset_pc;
    tb_order    = 64'd0;
    for (int i = 0; i < 32; i++) begin
      tb_regs[i] = 32'd0;
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b0;
    check_eq(64'(rpt_valid_o), 64'd0, "rpt_valid_o after reset");
    check_counts();
    test_alu_stream();
    test_control_flow();
    test_faults();
    test_unsupported();
    test_backpressure();
    $display("Regression passed");
    $finish;
  end

endmodule

//--- list.f
+incdir+testbench
common/rvfi_check_pkg.sv
rtl/insn_decode.sv
rtl/shadow_execute.sv
rtl/commit_compare.sv
rtl/rvfi_checker_top.sv
testbench/tb_rvfi_checker.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rvfi_checker
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
SIM_ARGS  ?=

BIN := V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o $(BIN)
	./$(OBJ_DIR)/$(BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
